// File: rtl/mram_bridge_pkg.sv
`default_nettype none

package mram_bridge_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and memory widths
    ////////////////////////////////////////////////////////////////////////////

    // One byte on the I2C bus
    typedef logic [7:0] byte_t;

    // MRAM word address and word
    typedef logic [19:0] mram_addr_t;
    typedef logic [15:0] mram_data_t;

    // Burst length nibble of the third address byte
    typedef logic [3:0] burst_len_t;

    // Upper five bits of the header byte
    typedef logic [4:0] slave_addr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam slave_addr_t SLAVE_ADDR = 5'b11111;

    // Flip-flops per pin in the input synchronizer
    localparam int SYNC_STAGES = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        ADDR,
        WR_DATA,
        RD_DATA,
        IGNORE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/i2c_line_monitor.sv
`default_nettype none

module i2c_line_monitor #(
    parameter int SYNC_STAGES = mram_bridge_pkg::SYNC_STAGES
) (
    input  wire  FPGA_clk,
    input  wire  FPGA_rst,
    input  wire  scl,
    input  wire  sda,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_det,
    output logic stop_det,
    output logic sda_bit
);

    // Stage 0 takes the pin, the last stage is the oldest sample
    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] sda_sync;

    logic scl_now;
    logic scl_old;
    logic sda_now;
    logic sda_old;

    assign scl_now = scl_sync[SYNC_STAGES-2];
    assign scl_old = scl_sync[SYNC_STAGES-1];
    assign sda_now = sda_sync[SYNC_STAGES-2];
    assign sda_old = sda_sync[SYNC_STAGES-1];

    // Lines idle high, so the chain starts at all ones
    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            scl_sync  <= '1;
            sda_sync  <= '1;
            scl_rise  <= 1'b0;
            scl_fall  <= 1'b0;
            start_det <= 1'b0;
            stop_det  <= 1'b0;
        end else begin
            scl_sync  <= {scl_sync[SYNC_STAGES-2:0], scl};
            sda_sync  <= {sda_sync[SYNC_STAGES-2:0], sda};
            scl_rise  <= scl_now && !scl_old;
            scl_fall  <= !scl_now && scl_old;
            // SDA moving while SCL stays high marks START or STOP
            start_det <= scl_now && scl_old && sda_old && !sda_now;
            stop_det  <= scl_now && scl_old && !sda_old && sda_now;
        end
    end

    // Lines up with the registered pulses above
    assign sda_bit = sda_old;

    a_start_stop_excl: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) !(start_det && stop_det)
    );

endmodule

`default_nettype wire

// File: rtl/i2c_byte_engine.sv
`default_nettype none

module i2c_byte_engine (
    input  wire                     FPGA_clk,
    input  wire                     FPGA_rst,
    input  wire                     scl_rise,
    input  wire                     scl_fall,
    input  wire                     start_det,
    input  wire                     sda_bit,
    input  wire                     bus_active,
    input  wire                     ack_byte,
    input  wire                     tx_mode,
    input  wire mram_bridge_pkg::byte_t tx_byte,
    output logic                    rx_valid,
    output mram_bridge_pkg::byte_t  rx_byte,
    output logic                    slot_end,
    output logic                    master_ack,
    output logic                    sda_pull
);

    // SCL rises seen so far in the nine-bit slot
    logic [3:0] bit_cnt;

    // Current byte goes out to the master
    logic byte_tx;

    // Set by the ninth rise, consumed by the following fall
    logic slot_pending;

    logic pull_q;

    mram_bridge_pkg::byte_t rx_shift;
    mram_bridge_pkg::byte_t tx_shift;

    ////////////////////////////////////////////////////////////////////////////
    // Slot counter and line drive
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            bit_cnt      <= '0;
            byte_tx      <= 1'b0;
            slot_pending <= 1'b0;
            pull_q       <= 1'b0;
            rx_valid     <= 1'b0;
            slot_end     <= 1'b0;
            master_ack   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            slot_end <= 1'b0;
            if (start_det) begin
                bit_cnt      <= '0;
                byte_tx      <= 1'b0;
                slot_pending <= 1'b0;
                pull_q       <= 1'b0;
            end else begin
                if (scl_rise) begin
                    if (bit_cnt == 4'd8) begin
                        // Acknowledge bit
                        bit_cnt      <= '0;
                        slot_end     <= 1'b1;
                        slot_pending <= 1'b1;
                        master_ack   <= !sda_bit;
                    end else begin
                        bit_cnt  <= bit_cnt + 4'd1;
                        rx_valid <= (bit_cnt == 4'd7) && !byte_tx;
                    end
                end
                if (scl_fall) begin
                    slot_pending <= 1'b0;
                    if (bit_cnt == 4'd0) begin
                        // New byte starts, MSB goes out now when sending
                        byte_tx <= slot_pending && tx_mode;
                        pull_q  <= slot_pending && tx_mode && !tx_byte[7];
                    end else if (bit_cnt == 4'd8) begin
                        pull_q <= !byte_tx && ack_byte;
                    end else begin
                        pull_q <= byte_tx && !tx_shift[7];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (scl_rise && (bit_cnt < 4'd8)) begin
            rx_shift <= {rx_shift[6:0], sda_bit};
        end
        if (scl_fall) begin
            if (bit_cnt == 4'd0) begin
                tx_shift <= {tx_byte[6:0], 1'b0};
            end else begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign rx_byte = rx_shift;

    // Released as soon as the controller drops the bus
    assign sda_pull = pull_q && bus_active;

    a_pull_stable_on_rise: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) scl_rise |-> $stable(sda_pull)
    );

    a_pull_needs_bus: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) !bus_active |-> !pull_q
    );

endmodule

`default_nettype wire

// File: rtl/mram_transaction_ctrl.sv
`default_nettype none

module mram_transaction_ctrl (
    input  wire                         FPGA_clk,
    input  wire                         FPGA_rst,
    input  wire                         start_det,
    input  wire                         stop_det,
    input  wire                         rx_valid,
    input  wire mram_bridge_pkg::byte_t rx_byte,
    input  wire                         slot_end,
    input  wire                         master_ack,
    input  wire mram_bridge_pkg::mram_data_t mram_rdata,
    output logic                        ack_byte,
    output logic                        tx_mode,
    output mram_bridge_pkg::byte_t      tx_byte,
    output logic                        bus_active,
    output mram_bridge_pkg::mram_addr_t mram_addr,
    output mram_bridge_pkg::mram_data_t mram_wdata,
    output logic                        mram_ce_n,
    output logic                        mram_oe_n,
    output logic                        mram_we_n,
    output logic                        mram_lb_n,
    output logic                        mram_ub_n
);

    mram_bridge_pkg::ctrl_state_t state;

    logic [1:0] addr_cnt;
    logic       sel_ub;
    logic       sel_lb;
    logic       sel_wr;
    logic       hi_half;
    logic       last_word;
    logic       wr_pend;

    mram_bridge_pkg::mram_addr_t base_addr;
    mram_bridge_pkg::burst_len_t burst_len;
    mram_bridge_pkg::burst_len_t word_cnt;
    mram_bridge_pkg::burst_len_t last_idx;
    mram_bridge_pkg::mram_data_t rd_word;

    // Burst of zero still moves one word
    assign last_idx = (burst_len == '0) ? '0 : burst_len - 4'd1;

    assign mram_addr = base_addr + mram_bridge_pkg::mram_addr_t'(word_cnt);
    assign tx_byte   = hi_half ? rd_word[15:8] : rd_word[7:0];

    assign mram_ce_n = mram_we_n && mram_oe_n;
    assign mram_lb_n = mram_ce_n || !sel_lb;
    assign mram_ub_n = mram_ce_n || !sel_ub;

    ////////////////////////////////////////////////////////////////////////////
    // Transaction FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge FPGA_clk) begin
        if (FPGA_rst) begin
            state      <= mram_bridge_pkg::IDLE;
            addr_cnt   <= '0;
            word_cnt   <= '0;
            hi_half    <= 1'b0;
            last_word  <= 1'b0;
            wr_pend    <= 1'b0;
            ack_byte   <= 1'b0;
            tx_mode    <= 1'b0;
            bus_active <= 1'b0;
            mram_oe_n  <= 1'b1;
            mram_we_n  <= 1'b1;
        end else begin
            // Write strobe lands two cycles after the high byte slot ends
            mram_we_n <= !wr_pend;
            wr_pend   <= 1'b0;
            if (!mram_we_n) begin
                word_cnt <= word_cnt + 4'd1;
            end
            if (stop_det || start_det) begin
                state      <= start_det ? mram_bridge_pkg::HEADER : mram_bridge_pkg::IDLE;
                bus_active <= start_det;
                ack_byte   <= 1'b0;
                tx_mode    <= 1'b0;
                hi_half    <= 1'b0;
                mram_oe_n  <= 1'b1;
            end else begin
                if (slot_end) begin
                    ack_byte <= 1'b0;
                end
                case (state)
                    mram_bridge_pkg::HEADER: begin
                        if (rx_valid && (rx_byte[7:3] == mram_bridge_pkg::SLAVE_ADDR)) begin
                            {sel_ub, sel_lb, sel_wr} <= rx_byte[2:0];
                            ack_byte <= 1'b1;
                            addr_cnt <= '0;
                            word_cnt <= '0;
                            state    <= mram_bridge_pkg::ADDR;
                        end else if (rx_valid) begin
                            bus_active <= 1'b0;
                            state      <= mram_bridge_pkg::IGNORE;
                        end
                    end
                    mram_bridge_pkg::ADDR: begin
                        if (rx_valid) begin
                            ack_byte <= 1'b1;
                            addr_cnt <= addr_cnt + 2'd1;
                            case (addr_cnt)
                                2'd0: base_addr[7:0]  <= rx_byte;
                                2'd1: base_addr[15:8] <= rx_byte;
                                default: begin
                                    burst_len        <= rx_byte[7:4];
                                    base_addr[19:16] <= rx_byte[3:0];
                                end
                            endcase
                        end
                        if (slot_end && (addr_cnt == 2'd3)) begin
                            if (sel_wr) begin
                                state <= mram_bridge_pkg::WR_DATA;
                            end else begin
                                state     <= mram_bridge_pkg::RD_DATA;
                                mram_oe_n <= 1'b0;
                                tx_mode   <= 1'b1;
                                rd_word   <= mram_rdata;
                            end
                        end
                    end
                    mram_bridge_pkg::WR_DATA: begin
                        if (rx_valid) begin
                            ack_byte <= 1'b1;
                            if (hi_half) begin
                                mram_wdata[15:8] <= rx_byte;
                            end else begin
                                mram_wdata[7:0] <= rx_byte;
                            end
                        end
                        if (slot_end) begin
                            hi_half <= !hi_half;
                            if (hi_half) begin
                                wr_pend <= ack_byte;
                                if (word_cnt == last_idx) begin
                                    state <= mram_bridge_pkg::IDLE;
                                end
                            end
                        end
                    end
                    mram_bridge_pkg::RD_DATA: begin
                        if (slot_end) begin
                            if (!master_ack || (hi_half && last_word)) begin
                                state     <= mram_bridge_pkg::IDLE;
                                tx_mode   <= 1'b0;
                                mram_oe_n <= 1'b1;
                            end else if (!hi_half) begin
                                // Word is held in rd_word, so the address may move on
                                hi_half   <= 1'b1;
                                last_word <= (word_cnt == last_idx);
                                if (word_cnt != last_idx) begin
                                    word_cnt <= word_cnt + 4'd1;
                                end
                            end else begin
                                hi_half <= 1'b0;
                                rd_word <= mram_rdata;
                            end
                        end
                    end
                    default: begin
                        // IDLE and IGNORE wait for START
                    end
                endcase
            end
        end
    end

    a_we_oe_excl: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) !(!mram_we_n && !mram_oe_n)
    );

    a_we_single_cycle: assert property (
        @(posedge FPGA_clk) disable iff (FPGA_rst) !mram_we_n |=> mram_we_n
    );

endmodule

`default_nettype wire

// File: rtl/i2c_mram_bridge.sv
`default_nettype none

module i2c_mram_bridge #(
    parameter int SYNC_STAGES = mram_bridge_pkg::SYNC_STAGES
) (
    input  wire                              FPGA_clk,
    input  wire                              FPGA_rst,
    input  wire                              scl,
    input  wire                              sda,
    output wire                              sda_pull,
    output wire mram_bridge_pkg::mram_addr_t mram_addr,
    output wire mram_bridge_pkg::mram_data_t mram_wdata,
    input  wire mram_bridge_pkg::mram_data_t mram_rdata,
    output wire                              mram_ce_n,
    output wire                              mram_oe_n,
    output wire                              mram_we_n,
    output wire                              mram_lb_n,
    output wire                              mram_ub_n
);

    ////////////////////////////////////////////////////////////////////////////
    // Bus events
    ////////////////////////////////////////////////////////////////////////////

    logic scl_rise;
    logic scl_fall;
    logic start_det;
    logic stop_det;
    logic sda_bit;

    i2c_line_monitor #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_line_monitor (
        .FPGA_clk  (FPGA_clk),
        .FPGA_rst  (FPGA_rst),
        .scl       (scl),
        .sda       (sda),
        .scl_rise  (scl_rise),
        .scl_fall  (scl_fall),
        .start_det (start_det),
        .stop_det  (stop_det),
        .sda_bit   (sda_bit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Byte level and transaction level
    ////////////////////////////////////////////////////////////////////////////

    logic                   rx_valid;
    mram_bridge_pkg::byte_t rx_byte;
    logic                   slot_end;
    logic                   master_ack;
    logic                   ack_byte;
    logic                   tx_mode;
    mram_bridge_pkg::byte_t tx_byte;
    logic                   bus_active;

    i2c_byte_engine i_byte_engine (
        .FPGA_clk   (FPGA_clk),
        .FPGA_rst   (FPGA_rst),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_det  (start_det),
        .sda_bit    (sda_bit),
        .bus_active (bus_active),
        .ack_byte   (ack_byte),
        .tx_mode    (tx_mode),
        .tx_byte    (tx_byte),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .slot_end   (slot_end),
        .master_ack (master_ack),
        .sda_pull   (sda_pull)
    );

    mram_transaction_ctrl i_transaction_ctrl (
        .FPGA_clk   (FPGA_clk),
        .FPGA_rst   (FPGA_rst),
        .start_det  (start_det),
        .stop_det   (stop_det),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .slot_end   (slot_end),
        .master_ack (master_ack),
        .mram_rdata (mram_rdata),
        .ack_byte   (ack_byte),
        .tx_mode    (tx_mode),
        .tx_byte    (tx_byte),
        .bus_active (bus_active),
        .mram_addr  (mram_addr),
        .mram_wdata (mram_wdata),
        .mram_ce_n  (mram_ce_n),
        .mram_oe_n  (mram_oe_n),
        .mram_we_n  (mram_we_n),
        .mram_lb_n  (mram_lb_n),
        .mram_ub_n  (mram_ub_n)
    );

endmodule

`default_nettype wire

// File: dv/i2c_master_tasks.svh
task automatic wait_clocks(input int n);
    repeat (n) @(posedge FPGA_clk);
endtask

// One SCL pulse, entered just after SCL was driven low
// A bit time is 16 FPGA_clk cycles, eight with SCL low and eight with SCL high
// SDA changes in the middle of the low phase and is sampled late in the high phase
task automatic clock_bit(input logic out_bit, output logic in_bit);
    wait_clocks(4);
    sda_rel <= out_bit;
    wait_clocks(4);
    scl <= 1'b1;
    wait_clocks(7);
    @(negedge FPGA_clk);
    in_bit = sda_pin;
    @(posedge FPGA_clk);
    scl <= 1'b0;
endtask

// SDA falls while SCL is high, then SCL goes low
task automatic send_start();
    @(posedge FPGA_clk);
    sda_rel <= 1'b1;
    scl     <= 1'b1;
    wait_clocks(8);
    sda_rel <= 1'b0;
    wait_clocks(8);
    scl <= 1'b0;
endtask

// SDA rises while SCL is high, bus left idle
task automatic send_stop();
    wait_clocks(4);
    sda_rel <= 1'b0;
    wait_clocks(4);
    scl <= 1'b1;
    wait_clocks(8);
    sda_rel <= 1'b1;
    wait_clocks(8);
endtask

// MSB first, then the ninth bit is released and the slave's answer returned
task automatic write_byte(input mram_bridge_pkg::byte_t data, output logic ack);
    mram_bridge_pkg::byte_t shift;
    logic unused_bit;
    shift = data;
    repeat (8) begin
        clock_bit(shift[7], unused_bit);
        shift = {shift[6:0], 1'b0};
    end
    clock_bit(1'b1, ack);
endtask

// Line released for eight bits, then ack_out driven in the ninth
task automatic read_byte(input logic ack_out, output mram_bridge_pkg::byte_t data);
    logic rx_bit;
    logic unused_bit;
    data = '0;
    repeat (8) begin
        clock_bit(1'b1, rx_bit);
        data = {data[6:0], rx_bit};
    end
    clock_bit(ack_out, unused_bit);
endtask

// File: dv/tb_i2c_mram_bridge.sv
`default_nettype none

module tb_i2c_mram_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int N_DIRECTED   = 10;
    localparam int N_RANDOM     = 16;
    // Longest transaction is four header bytes and 15 words, plus START and STOP
    localparam int TXN_BITS_MAX = 9 * (4 + 30) + 3;
    localparam int PLANNED_BITS = (N_DIRECTED + N_RANDOM) * TXN_BITS_MAX;
    localparam int WATCHDOG_NS  = 2 * PLANNED_BITS * 16 * CLK_PERIOD;

    logic FPGA_clk;
    logic FPGA_rst;
    logic scl;
    logic sda_rel;
    logic sda_pin;
    logic sda_pull;
    logic mram_ce_n;
    logic mram_oe_n;
    logic mram_we_n;
    logic mram_lb_n;
    logic mram_ub_n;
    mram_bridge_pkg::mram_addr_t mram_addr;
    mram_bridge_pkg::mram_data_t mram_wdata;
    mram_bridge_pkg::mram_data_t mram_rdata;

    // Model memory written by the DUT, reference memory written by the stimulus
    mram_bridge_pkg::mram_data_t mem [mram_bridge_pkg::mram_addr_t];
    mram_bridge_pkg::mram_data_t ref_mem [mram_bridge_pkg::mram_addr_t];
    mram_bridge_pkg::mram_addr_t exp_addr_q [$];
    mram_bridge_pkg::mram_data_t exp_data_q [$];

    // Open drain line
    assign sda_pin = sda_rel & ~sda_pull;

    i2c_mram_bridge #(
        .SYNC_STAGES (mram_bridge_pkg::SYNC_STAGES)
    ) i_dut (
        .FPGA_clk   (FPGA_clk),
        .FPGA_rst   (FPGA_rst),
        .scl        (scl),
        .sda        (sda_pin),
        .sda_pull   (sda_pull),
        .mram_addr  (mram_addr),
        .mram_wdata (mram_wdata),
        .mram_rdata (mram_rdata),
        .mram_ce_n  (mram_ce_n),
        .mram_oe_n  (mram_oe_n),
        .mram_we_n  (mram_we_n),
        .mram_lb_n  (mram_lb_n),
        .mram_ub_n  (mram_ub_n)
    );

    `include "i2c_master_tasks.svh"

    initial begin
        FPGA_clk = 1'b0;
        forever #(CLK_PERIOD / 2) FPGA_clk = ~FPGA_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input mram_bridge_pkg::mram_data_t expected,
                              input mram_bridge_pkg::mram_data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input mram_bridge_pkg::mram_addr_t expected,
                              input mram_bridge_pkg::mram_addr_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s expected %b, got %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_strobe(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s expected %b, got %b",
                                $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory helpers
    ////////////////////////////////////////////////////////////////////////////

    // lanes[1] is the upper byte, lanes[0] the lower byte
    function automatic mram_bridge_pkg::mram_data_t merge_lanes(
        input mram_bridge_pkg::mram_data_t old_word,
        input mram_bridge_pkg::mram_data_t new_word,
        input logic [1:0] lanes
    );
        mram_bridge_pkg::mram_data_t merged;
        merged = old_word;
        if (lanes[0]) begin
            merged[7:0] = new_word[7:0];
        end
        if (lanes[1]) begin
            merged[15:8] = new_word[15:8];
        end
        return merged;
    endfunction

    function automatic mram_bridge_pkg::mram_data_t model_word(
        input mram_bridge_pkg::mram_addr_t a
    );
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '0;
    endfunction

    function automatic mram_bridge_pkg::mram_data_t ref_word(input mram_bridge_pkg::mram_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return '0;
    endfunction

    // Strobes and read data of the MRAM model are handled on the falling clock edge
    initial begin : mram_model
        logic [1:0] lanes;
        mram_rdata = '0;
        forever begin
            @(negedge FPGA_clk);
            if (!FPGA_rst && !mram_we_n && !mram_ce_n) begin
                if (exp_addr_q.size() == 0) begin
                    abort_run("MRAM write strobe seen while no write word was pending");
                end
                check_addr("mram_addr", exp_addr_q.pop_front(), mram_addr);
                check_data("mram_wdata", exp_data_q.pop_front(), mram_wdata);
                lanes = {!mram_ub_n, !mram_lb_n};
                mem[mram_addr] = merge_lanes(model_word(mram_addr), mram_wdata, lanes);
            end
            mram_rdata = model_word(mram_addr);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Simulation timed out before all transactions finished");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transactions
    ////////////////////////////////////////////////////////////////////////////

    // Header byte and the three address bytes, each must be acknowledged
    task automatic send_header(input mram_bridge_pkg::mram_addr_t base,
                               input mram_bridge_pkg::burst_len_t burst, input logic [2:0] sel);
        logic ack;
        write_byte({mram_bridge_pkg::SLAVE_ADDR, sel}, ack);
        check_ack("header ack", 1'b0, ack);
        write_byte(base[7:0], ack);
        check_ack("address byte 0 ack", 1'b0, ack);
        write_byte(base[15:8], ack);
        check_ack("address byte 1 ack", 1'b0, ack);
        write_byte({burst, base[19:16]}, ack);
        check_ack("address byte 2 ack", 1'b0, ack);
    endtask

    task automatic write_burst(input mram_bridge_pkg::mram_addr_t base,
                               input mram_bridge_pkg::burst_len_t burst, input logic [1:0] lanes);
        mram_bridge_pkg::mram_addr_t a;
        mram_bridge_pkg::mram_data_t word;
        logic ack;
        int words;
        int w;
        int waited;
        words = (burst == 4'd0) ? 1 : int'(burst);
        send_start();
        send_header(base, burst, {lanes, 1'b1});
        for (w = 0; w < words; w++) begin
            a    = base + mram_bridge_pkg::mram_addr_t'(w);
            word = mram_bridge_pkg::mram_data_t'($urandom);
            exp_addr_q.push_back(a);
            exp_data_q.push_back(word);
            ref_mem[a] = merge_lanes(ref_word(a), word, lanes);
            write_byte(word[7:0], ack);
            check_ack("data low byte ack", 1'b0, ack);
            write_byte(word[15:8], ack);
            check_ack("data high byte ack", 1'b0, ack);
        end
        send_stop();
        waited = 0;
        while ((exp_addr_q.size() != 0) && (waited < 32)) begin
            @(posedge FPGA_clk);
            waited++;
        end
        if (exp_addr_q.size() != 0) begin
            abort_run("MRAM write strobe missing after a write burst");
        end
    endtask

    // Output enable stays low through the burst and is released after the last word
    task automatic read_burst(input mram_bridge_pkg::mram_addr_t base,
                              input mram_bridge_pkg::burst_len_t burst);
        mram_bridge_pkg::mram_addr_t a;
        mram_bridge_pkg::byte_t lo;
        mram_bridge_pkg::byte_t hi;
        int words;
        int w;
        words = (burst == 4'd0) ? 1 : int'(burst);
        send_start();
        send_header(base, burst, 3'b110);
        for (w = 0; w < words; w++) begin
            a = base + mram_bridge_pkg::mram_addr_t'(w);
            read_byte(1'b0, lo);
            check_strobe("mram_oe_n", 1'b0, mram_oe_n);
            check_strobe("mram_ce_n", 1'b0, mram_ce_n);
            read_byte(1'b0, hi);
            check_data($sformatf("read word at %h", a), ref_word(a), {hi, lo});
        end
        check_strobe("mram_oe_n after the last word", 1'b1, mram_oe_n);
        send_stop();
    endtask

    // Header with a foreign slave address, followed by bytes that must stay unanswered
    task automatic ignored_header();
        mram_bridge_pkg::slave_addr_t bad;
        logic ack;
        bad = mram_bridge_pkg::slave_addr_t'($urandom_range(30, 0));
        send_start();
        write_byte({bad, 3'b111}, ack);
        check_ack("header ack on foreign address", 1'b1, ack);
        repeat (5) begin
            write_byte(mram_bridge_pkg::byte_t'($urandom), ack);
            check_ack("ack while ignored", 1'b1, ack);
        end
        send_stop();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        mram_bridge_pkg::mram_addr_t base;
        mram_bridge_pkg::burst_len_t burst;
        logic [1:0]  lanes;
        logic [13:0] page;
        int n;
        void'($urandom(74683));
        FPGA_rst   = 1'b1;
        scl        = 1'b1;
        sda_rel    = 1'b1;
        repeat (5) @(posedge FPGA_clk);
        FPGA_rst <= 1'b0;
        wait_clocks(8);

        ignored_header();

        // Single word, then a burst, each read back
        base = mram_bridge_pkg::mram_addr_t'($urandom);
        write_burst(base, 4'd0, 2'b11);
        read_burst(base, 4'd0);
        base  = mram_bridge_pkg::mram_addr_t'($urandom);
        burst = mram_bridge_pkg::burst_len_t'($urandom_range(15, 2));
        write_burst(base, burst, 2'b11);
        read_burst(base, burst);
        read_burst(base - mram_bridge_pkg::mram_addr_t'(3), 4'd15);

        // One lane at a time over a fully written pair
        base = mram_bridge_pkg::mram_addr_t'($urandom);
        write_burst(base, 4'd2, 2'b11);
        write_burst(base, 4'd1, 2'b10);
        write_burst(base + mram_bridge_pkg::mram_addr_t'(1), 4'd1, 2'b01);
        read_burst(base, 4'd2);

        // Random mix inside one 64-word window so that reads hit written words
        page = 14'($urandom);
        for (n = 0; n < N_RANDOM; n++) begin
            base  = {page, 6'($urandom)};
            burst = mram_bridge_pkg::burst_len_t'($urandom);
            lanes = 2'($urandom);
            if ($urandom_range(1, 0) == 1) begin
                write_burst(base, burst, lanes);
            end else begin
                read_burst(base, burst);
            end
        end

        if (mem.num() != ref_mem.num()) begin
            abort_run("Model memory and reference memory hold different numbers of words");
        end
        foreach (ref_mem[a]) begin
            check_data($sformatf("mem[%h]", a), ref_mem[a], model_word(a));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+dv
rtl/mram_bridge_pkg.sv
rtl/i2c_line_monitor.sv
rtl/i2c_byte_engine.sv
rtl/mram_transaction_ctrl.sv
rtl/i2c_mram_bridge.sv
dv/tb_i2c_mram_bridge.sv

// File: Makefile
# Verilator build and run of the I2C to MRAM bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_mram_bridge
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Pass or fail is read from the log, not from the exit status of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
